//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef enum logic [4:0] {
    HALT    = 5'b00000,
    NOP     = 5'b00001,
    J       = 5'b00100,
    JR      = 5'b00101,
    JAL     = 5'b00110,
    JALR    = 5'b00111,
    ADDI    = 5'b01000,
    SUBI    = 5'b01001,
    XORI    = 5'b01010,
    ANDNI   = 5'b01011,
    BEQZ    = 5'b01100,
    BNEZ    = 5'b01101,
    BLTZ    = 5'b01110,
    BGEZ    = 5'b01111,
    ST      = 5'b10000,
    LD      = 5'b10001,
    SLBI    = 5'b10010,
    STU     = 5'b10011,
    ROLI    = 5'b10100,
    SLLI    = 5'b10101,
    RORI    = 5'b10110,
    SRLI    = 5'b10111,
    LBI     = 5'b11000,
    BTR     = 5'b11001,
    SHIFT_R = 5'b11010,  // ROL/SLL/ROR/SRL by ext
    ALU_R   = 5'b11011,  // ADD/SUB/XOR/ANDN by ext
    SEQ     = 5'b11100,
    SLT     = 5'b11101,
    SLE     = 5'b11110,
    SCO     = 5'b11111
  } opcode_e;

  localparam int          NUM_REGS = 8;
  localparam logic [2:0]  LINK_REG = 3'd7;   // r7 gets PC+2 on JAL/JALR
  localparam logic [15:0] NOP_WORD = 16'h0800;

  // ALU op classes; the low two bits come from the opcode where noted
  localparam logic [3:0] ALU_ADD = 4'h0;
  localparam logic [3:0] ALU_XOR = 4'h1;
  localparam logic [3:0] ALU_AND = 4'h2;   // ANDN when inv_b is set
  localparam logic [3:0] ALU_ROL = 4'h4;   // 4..7 rol, sll, ror, srl
  localparam logic [3:0] ALU_SEQ = 4'h8;   // 8..11 seq, slt, sle, sco

  localparam logic [1:0] WB_ALU = 2'd0;
  localparam logic [1:0] WB_MEM = 2'd1;
  localparam logic [1:0] WB_PC2 = 2'd2;
  localparam logic [1:0] WB_IMM = 2'd3;

  localparam logic [1:0] B_REG  = 2'd0;
  localparam logic [1:0] B_IMM5 = 2'd1;
  localparam logic [1:0] B_IMM8 = 2'd2;
  localparam logic [1:0] B_ZERO = 2'd3;

  localparam logic [1:0] DST_RS   = 2'd0;
  localparam logic [1:0] DST_RT   = 2'd1;
  localparam logic [1:0] DST_RD   = 2'd2;
  localparam logic [1:0] DST_LINK = 2'd3;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    logic [1:0] ext;
  } r_fmt_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] rs;
    logic [2:0] rd;    // Same bits as r_fmt.rt
    logic [4:0] imm5;
  } i1_fmt_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] rs;
    logic [7:0] imm8;
  } i2_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [10:0] disp11;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t  r_fmt;
    i1_fmt_t i1_fmt;
    i2_fmt_t i2_fmt;
    j_fmt_t  j_fmt;
  } instr_u;

  typedef struct packed {
    logic [3:0] alu_op;
    logic [1:0] wb_sel;
    logic [1:0] b_sel;
    logic [1:0] reg_dst;
    logic       reg_write;
    logic       slbi;
    logic       branch;
    logic       zero_ext;
    logic       set_op;
    logic       sub;        // Carry in of the adder
    logic       mem_en;
    logic       inv_a;
    logic       inv_b;
    logic       mem_write;
    logic       imm_sel;    // 1 picks disp11, 0 picks imm8 for targets
    logic       alu_jmp;
    logic       halt;
    logic       btr;
    logic       jmp;
  } ctrl_t;

  typedef struct packed {
    logic        write_en;
    logic [2:0]  write_sel;
    logic [15:0] write_data;
  } wb_t;

  typedef struct packed {
    logic       mem_read;
    logic [2:0] rt;
  } ex_info_t;

  typedef struct packed {
    logic [15:0] read1;
    logic [15:0] read2;
    logic [15:0] imm5_ext;
    logic [15:0] imm8_ext;
    logic [15:0] imm11_ext;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [2:0]  wr_sel;
    logic [1:0]  ext;
    logic [1:0]  branch_sel;
    logic [15:0] instr;
  } dec_out_t;

endpackage

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  wire isa_pkg::opcode_e opcode,
  output isa_pkg::ctrl_t        ctrl
);

  always_comb begin
    ctrl = '0;
    case (opcode)
      isa_pkg::HALT: begin
        ctrl.halt = 1'b1;
      end
      isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::XORI, isa_pkg::ANDNI: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RT;
        ctrl.b_sel     = isa_pkg::B_IMM5;
        ctrl.wb_sel    = isa_pkg::WB_ALU;
        ctrl.zero_ext  = opcode[1];                  // XORI, ANDNI are unsigned
        ctrl.inv_a     = (opcode == isa_pkg::SUBI);  // imm - rs
        ctrl.sub       = (opcode == isa_pkg::SUBI);
        ctrl.inv_b     = (opcode == isa_pkg::ANDNI);
        ctrl.alu_op    = (opcode == isa_pkg::XORI)  ? isa_pkg::ALU_XOR :
                         (opcode == isa_pkg::ANDNI) ? isa_pkg::ALU_AND : isa_pkg::ALU_ADD;
      end
      isa_pkg::ROLI, isa_pkg::SLLI, isa_pkg::RORI, isa_pkg::SRLI: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RT;
        ctrl.b_sel     = isa_pkg::B_IMM5;
        ctrl.zero_ext  = 1'b1;
        ctrl.alu_op    = isa_pkg::ALU_ROL | {2'b00, opcode[1:0]};  // Shift kind from opcode
      end
      isa_pkg::ST, isa_pkg::LD, isa_pkg::STU: begin
        ctrl.mem_en    = 1'b1;
        ctrl.b_sel     = isa_pkg::B_IMM5;
        ctrl.alu_op    = isa_pkg::ALU_ADD;               // rs + imm5 address
        ctrl.mem_write = (opcode != isa_pkg::LD);
        ctrl.reg_write = (opcode != isa_pkg::ST);
        ctrl.reg_dst   = (opcode == isa_pkg::LD) ? isa_pkg::DST_RT : isa_pkg::DST_RS;
        ctrl.wb_sel    = (opcode == isa_pkg::LD) ? isa_pkg::WB_MEM : isa_pkg::WB_ALU;
      end
      isa_pkg::BTR: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RD;
        ctrl.b_sel     = isa_pkg::B_ZERO;
        ctrl.btr       = 1'b1;
      end
      isa_pkg::ALU_R, isa_pkg::SHIFT_R: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RD;
        ctrl.b_sel     = isa_pkg::B_REG;
        // Class only, execute picks the exact op from ext
        ctrl.alu_op    = (opcode == isa_pkg::SHIFT_R) ? isa_pkg::ALU_ROL : isa_pkg::ALU_ADD;
      end
      isa_pkg::SEQ, isa_pkg::SLT, isa_pkg::SLE, isa_pkg::SCO: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RD;
        ctrl.b_sel     = isa_pkg::B_REG;
        ctrl.set_op    = 1'b1;
        ctrl.alu_op    = isa_pkg::ALU_SEQ | {2'b00, opcode[1:0]};
        ctrl.sub       = (opcode != isa_pkg::SCO);  // Compare as rs - rt
        ctrl.inv_b     = (opcode != isa_pkg::SCO);
      end
      isa_pkg::BEQZ, isa_pkg::BNEZ, isa_pkg::BLTZ, isa_pkg::BGEZ: begin
        ctrl.branch = 1'b1;
        ctrl.b_sel  = isa_pkg::B_ZERO;  // rs passes through for the zero test
      end
      isa_pkg::LBI: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RS;
        ctrl.wb_sel    = isa_pkg::WB_IMM;
      end
      isa_pkg::SLBI: begin
        // Execute forms (rs << 8) | imm8
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = isa_pkg::DST_RS;
        ctrl.b_sel     = isa_pkg::B_IMM8;
        ctrl.zero_ext  = 1'b1;
        ctrl.slbi      = 1'b1;
      end
      isa_pkg::J, isa_pkg::JAL: begin
        ctrl.jmp       = 1'b1;
        ctrl.imm_sel   = 1'b1;
        ctrl.reg_write = opcode[1];  // Link on JAL
        ctrl.reg_dst   = opcode[1] ? isa_pkg::DST_LINK : isa_pkg::DST_RS;
        ctrl.wb_sel    = opcode[1] ? isa_pkg::WB_PC2 : isa_pkg::WB_ALU;
      end
      isa_pkg::JR, isa_pkg::JALR: begin
        ctrl.alu_jmp   = 1'b1;
        ctrl.b_sel     = isa_pkg::B_IMM8;  // Target rs + imm8
        ctrl.alu_op    = isa_pkg::ALU_ADD;
        ctrl.reg_write = opcode[1];
        ctrl.reg_dst   = opcode[1] ? isa_pkg::DST_LINK : isa_pkg::DST_RS;
        ctrl.wb_sel    = opcode[1] ? isa_pkg::WB_PC2 : isa_pkg::WB_ALU;
      end
      default: begin
        ctrl = '0;  // NOP and unused codes
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/reg_file_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file_bypass (
  input  wire               clk,
  input  wire               arst_n,
  input  wire [2:0]         rd1_sel,
  input  wire [2:0]         rd2_sel,
  input  wire isa_pkg::wb_t wb,
  output logic [15:0]       rd1_data,
  output logic [15:0]       rd2_data
);

  logic [15:0] regs [isa_pkg::NUM_REGS];
  logic        hit1;
  logic        hit2;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.write_en) begin
      regs[wb.write_sel] <= wb.write_data;
    end
  end

  // Write-back lands at the edge, so forward it to a same-cycle read
  assign hit1 = wb.write_en && (wb.write_sel == rd1_sel);
  assign hit2 = wb.write_en && (wb.write_sel == rd2_sel);

  assign rd1_data = hit1 ? wb.write_data : regs[rd1_sel];
  assign rd2_data = hit2 ? wb.write_data : regs[rd2_sel];

endmodule

`default_nettype wire

//--- logic/load_use_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module load_use_hazard (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    stall,
  input  wire isa_pkg::ex_info_t ex,
  input  wire                    pc_src,
  input  wire [2:0]              src_rs,
  input  wire [2:0]              src_rt,
  output logic                   data_hazard,
  output logic                   flush
);

  logic pc_src_q;   // Second flush cycle
  logic rs_match;
  logic rt_match;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_src_q <= 1'b0;
    end else begin
      pc_src_q <= pc_src;
    end
  end

  assign rs_match = (ex.rt == src_rs);
  assign rt_match = (ex.rt == src_rt);

  // Load in execute feeds a source of the word in decode
  assign data_hazard = ex.mem_read && !stall && (rs_match || rt_match);

  // Kill the two younger words behind a taken branch or jump
  assign flush = pc_src | pc_src_q;

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    dmem_stall,
  input  wire                    imem_stall,
  input  wire isa_pkg::instr_u   instr_fd,
  input  wire isa_pkg::wb_t      wb,
  input  wire                    pc_src,
  input  wire isa_pkg::ex_info_t ex,
  output isa_pkg::ctrl_t         ctrl,
  output isa_pkg::dec_out_t      dec,
  output logic                   data_hazard,
  output logic                   flush
);

  isa_pkg::instr_u instr_q;    // Word from the previous cycle
  logic            hazard_q;
  isa_pkg::instr_u instr;      // Word actually decoded
  logic            stall;
  logic [15:0]     read1;
  logic [15:0]     read2;
  logic [4:0]      imm5;
  logic [7:0]      imm8;
  logic [10:0]     imm11;

  assign stall = dmem_stall | imem_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_q  <= isa_pkg::NOP_WORD;
      hazard_q <= 1'b0;
    end else begin
      instr_q  <= instr_fd;
      hazard_q <= data_hazard;
    end
  end

  always_comb begin
    if (data_hazard || flush || dmem_stall) begin
      instr = isa_pkg::NOP_WORD;  // Bubble
    end else if (hazard_q && (instr_q != isa_pkg::NOP_WORD)) begin
      instr = instr_q;            // Replay the word held back by the bubble
    end else begin
      instr = instr_fd;
    end
  end

  instr_decoder u_instr_decoder (
    .opcode (instr.r_fmt.opcode),
    .ctrl   (ctrl)
  );

  reg_file_bypass u_reg_file_bypass (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd1_sel  (instr.r_fmt.rs),
    .rd2_sel  (instr.r_fmt.rt),
    .wb       (wb),
    .rd1_data (read1),
    .rd2_data (read2)
  );

  load_use_hazard u_load_use_hazard (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .ex          (ex),
    .pc_src      (pc_src),
    .src_rs      (instr_fd.r_fmt.rs),  // Incoming word, not the selected one
    .src_rt      (instr_fd.r_fmt.rt),
    .data_hazard (data_hazard),
    .flush       (flush)
  );

  assign imm5  = instr.i1_fmt.imm5;
  assign imm8  = instr.i2_fmt.imm8;
  assign imm11 = instr.j_fmt.disp11;

  always_comb begin
    dec.read1     = read1;
    dec.read2     = read2;
    dec.imm5_ext  = ctrl.zero_ext ? {11'd0, imm5} : {{11{imm5[4]}}, imm5};
    dec.imm8_ext  = ctrl.zero_ext ? {8'd0, imm8} : {{8{imm8[7]}}, imm8};
    dec.imm11_ext = {{5{imm11[10]}}, imm11};  // Jump displacement is always signed
    dec.rs        = instr.r_fmt.rs;
    dec.rt        = instr.r_fmt.rt;
    case (ctrl.reg_dst)
      isa_pkg::DST_RS: dec.wr_sel = instr.r_fmt.rs;
      isa_pkg::DST_RT: dec.wr_sel = instr.r_fmt.rt;
      isa_pkg::DST_RD: dec.wr_sel = instr.r_fmt.rd;
      default:         dec.wr_sel = isa_pkg::LINK_REG;
    endcase
    dec.ext        = instr.r_fmt.ext;
    dec.branch_sel = instr.r_fmt.opcode[1:0];  // Picks the branch condition
    dec.instr      = instr;
  end

endmodule

`default_nettype wire

//--- tb/decode_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assert (
  input wire        clk,
  input wire        arst_n,
  input wire        pc_src,
  input wire        data_hazard,
  input wire        flush,
  input wire [15:0] instr
);

  // A killed slot decodes as a bubble
  property bubble_on_kill;
    @(posedge clk) disable iff (!arst_n)
      (data_hazard || flush) |-> (instr == isa_pkg::NOP_WORD);
  endproperty

  property flush_after_pc_src;
    @(posedge clk) disable iff (!arst_n)
      pc_src |=> flush;
  endproperty

  property quiet_after_reset;
    @(posedge clk) $rose(arst_n) |-> (!data_hazard && !flush);
  endproperty

  a_bubble_on_kill: assert property (bubble_on_kill)
    else $error("hazard or flush slot decoded a live word");
  a_flush_after_pc_src: assert property (flush_after_pc_src)
    else $error("flush did not follow pc_src in the next cycle");
  a_quiet_after_reset: assert property (quiet_after_reset)
    else $error("hazard or flush active right after reset");

endmodule

bind decode_stage decode_stage_assert u_decode_stage_assert (
  .clk         (clk),
  .arst_n      (arst_n),
  .pc_src      (pc_src),
  .data_hazard (data_hazard),
  .flush       (flush),
  .instr       (instr)
);

`default_nettype wire

//--- tb/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  localparam int SCRIPT_CYCLES = 228;
  localparam int MAX_CYCLES    = 4 * SCRIPT_CYCLES;

  typedef struct packed {
    logic [15:0] imm5;
    logic [15:0] imm8;
    logic [15:0] imm11;
    logic [2:0]  wr_sel;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [1:0]  ext;
    logic [1:0]  branch_sel;
  } ref_dec_t;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  dmem_stall;
  logic                  imem_stall;
  isa_pkg::instr_u       instr_fd;
  isa_pkg::wb_t          wb;
  logic                  pc_src;
  isa_pkg::ex_info_t     ex;
  isa_pkg::ctrl_t        ctrl;
  isa_pkg::dec_out_t     dec;
  logic                  data_hazard;
  logic                  flush;

  logic [31:0] lcg_state = 32'd85518;
  logic [15:0] exp_instr;    // Word the stage should decode this cycle
  logic        exp_hazard;
  logic        exp_flush;
  logic [15:0] exp_read;
  logic        chk_en;
  logic        chk_read;
  ref_dec_t    exp_dec;
  string       test_name;
  int          checks;
  int          errors;
  int          cycles;

  decode_stage u_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .dmem_stall  (dmem_stall),
    .imem_stall  (imem_stall),
    .instr_fd    (instr_fd),
    .wb          (wb),
    .pc_src      (pc_src),
    .ex          (ex),
    .ctrl        (ctrl),
    .dec         (dec),
    .data_hazard (data_hazard),
    .flush       (flush)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Control bundle per opcode, group settings first and then the odd ones
  function automatic isa_pkg::ctrl_t ref_ctrl(input logic [4:0] op);
    isa_pkg::ctrl_t c;
    c = '0;
    case (op)
      isa_pkg::HALT: c.halt = 1'b1;
      isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::XORI, isa_pkg::ANDNI,
      isa_pkg::ROLI, isa_pkg::SLLI, isa_pkg::RORI, isa_pkg::SRLI: begin
        c.reg_write = 1'b1;
        c.reg_dst   = isa_pkg::DST_RT;
        c.b_sel     = isa_pkg::B_IMM5;
      end
      isa_pkg::ST, isa_pkg::LD, isa_pkg::STU: begin
        c.mem_en = 1'b1;
        c.b_sel  = isa_pkg::B_IMM5;
      end
      isa_pkg::BTR, isa_pkg::ALU_R, isa_pkg::SHIFT_R,
      isa_pkg::SEQ, isa_pkg::SLT, isa_pkg::SLE, isa_pkg::SCO: begin
        c.reg_write = 1'b1;
        c.reg_dst   = isa_pkg::DST_RD;
      end
      isa_pkg::BEQZ, isa_pkg::BNEZ, isa_pkg::BLTZ, isa_pkg::BGEZ: begin
        c.branch = 1'b1;
        c.b_sel  = isa_pkg::B_ZERO;
      end
      isa_pkg::LBI: begin
        c.reg_write = 1'b1;
        c.wb_sel    = isa_pkg::WB_IMM;
      end
      isa_pkg::SLBI: begin
        c.reg_write = 1'b1;
        c.b_sel     = isa_pkg::B_IMM8;
        c.zero_ext  = 1'b1;
        c.slbi      = 1'b1;
      end
      isa_pkg::J, isa_pkg::JAL: begin
        c.jmp     = 1'b1;
        c.imm_sel = 1'b1;
      end
      isa_pkg::JR, isa_pkg::JALR: begin
        c.alu_jmp = 1'b1;
        c.b_sel   = isa_pkg::B_IMM8;
      end
      default: c = '0;
    endcase
    case (op)
      isa_pkg::SUBI: begin
        c.inv_a = 1'b1;
        c.sub   = 1'b1;
      end
      isa_pkg::XORI: begin
        c.zero_ext = 1'b1;
        c.alu_op   = 4'h1;
      end
      isa_pkg::ANDNI: begin
        c.zero_ext = 1'b1;
        c.inv_b    = 1'b1;
        c.alu_op   = 4'h2;
      end
      isa_pkg::ROLI, isa_pkg::SLLI, isa_pkg::RORI, isa_pkg::SRLI: begin
        c.zero_ext = 1'b1;
        c.alu_op   = {2'b01, op[1:0]};  // rol, sll, ror, srl in code order
      end
      isa_pkg::ST: c.mem_write = 1'b1;
      isa_pkg::LD: begin
        c.reg_write = 1'b1;
        c.reg_dst   = isa_pkg::DST_RT;
        c.wb_sel    = isa_pkg::WB_MEM;
      end
      isa_pkg::STU: begin
        c.mem_write = 1'b1;
        c.reg_write = 1'b1;
      end
      isa_pkg::BTR: begin
        c.b_sel = isa_pkg::B_ZERO;
        c.btr   = 1'b1;
      end
      isa_pkg::SHIFT_R: c.alu_op = 4'h4;
      isa_pkg::SEQ, isa_pkg::SLT, isa_pkg::SLE: begin
        c.set_op = 1'b1;
        c.sub    = 1'b1;
        c.inv_b  = 1'b1;
        c.alu_op = {2'b10, op[1:0]};
      end
      isa_pkg::SCO: begin
        c.set_op = 1'b1;
        c.alu_op = 4'hb;
      end
      isa_pkg::JAL, isa_pkg::JALR: begin
        c.reg_write = 1'b1;
        c.reg_dst   = isa_pkg::DST_LINK;
        c.wb_sel    = isa_pkg::WB_PC2;
      end
      default: c = c;
    endcase
    return c;
  endfunction

  // Fields by bit position: rs 10:8, rt 7:5, rd 4:2, ext 1:0
  function automatic ref_dec_t ref_dec(input logic [15:0] w, input isa_pkg::ctrl_t c);
    ref_dec_t d;
    d.imm5  = c.zero_ext ? {11'd0, w[4:0]} : {{11{w[4]}}, w[4:0]};
    d.imm8  = c.zero_ext ? {8'd0, w[7:0]} : {{8{w[7]}}, w[7:0]};
    d.imm11 = {{5{w[10]}}, w[10:0]};
    case (c.reg_dst)
      2'd0:    d.wr_sel = w[10:8];
      2'd1:    d.wr_sel = w[7:5];
      2'd2:    d.wr_sel = w[4:2];
      default: d.wr_sel = 3'd7;
    endcase
    d.rs         = w[10:8];
    d.rt         = w[7:5];
    d.ext        = w[1:0];
    d.branch_sel = w[12:11];  // Low opcode bits
    return d;
  endfunction

  task automatic check(input string field, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s %s: expected %0h, actual %0h at %0t", test_name, field,
               expected, actual, $time);
    end
  endtask

  // One cycle of stimulus plus what the stage should show for it
  task automatic apply(input logic [15:0] word, input logic mem_read, input logic [2:0] ex_rt,
                       input logic pc, input logic dstall, input logic istall,
                       input logic [15:0] exp_word, input logic exp_haz, input logic exp_fl);
    @(posedge clk);
    instr_fd   <= word;
    ex         <= {mem_read, ex_rt};
    pc_src     <= pc;
    dmem_stall <= dstall;
    imem_stall <= istall;
    exp_instr  <= exp_word;
    exp_hazard <= exp_haz;
    exp_flush  <= exp_fl;
    chk_en     <= 1'b1;
  endtask

  task automatic write_read(input logic [2:0] r, input logic [15:0] value);
    logic [15:0] word;
    word = {isa_pkg::ALU_R, r, r, 5'd0};  // Reads r on both ports
    apply(word, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, word, 1'b0, 1'b0);
    wb       <= {1'b1, r, value};         // Same cycle, so the bypass answers
    exp_read <= value;
    chk_read <= 1'b1;
    apply(word, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, word, 1'b0, 1'b0);
    wb       <= '0;                       // Now it comes from the array
  endtask

  always @(negedge clk) begin
    if (chk_en) begin
      exp_dec = ref_dec(exp_instr, ref_ctrl(exp_instr[15:11]));
      check("instr", exp_instr, dec.instr);
      check("ctrl", ref_ctrl(exp_instr[15:11]), ctrl);
      check("imm5_ext", exp_dec.imm5, dec.imm5_ext);
      check("imm8_ext", exp_dec.imm8, dec.imm8_ext);
      check("imm11_ext", exp_dec.imm11, dec.imm11_ext);
      check("wr_sel", exp_dec.wr_sel, dec.wr_sel);
      check("rs", exp_dec.rs, dec.rs);
      check("rt", exp_dec.rt, dec.rt);
      check("ext", exp_dec.ext, dec.ext);
      check("branch_sel", exp_dec.branch_sel, dec.branch_sel);
      check("data_hazard", exp_hazard, data_hazard);
      check("flush", exp_flush, flush);
      if (chk_read) begin
        check("read1", exp_read, dec.read1);
        check("read2", exp_read, dec.read2);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not end within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    logic [15:0] w_load;
    logic [15:0] w_next;
    w_load     = {isa_pkg::ADDI, 3'd3, 3'd1, 5'd5};  // rs = r3
    w_next     = {isa_pkg::XORI, 3'd2, 3'd4, 5'd9};
    arst_n     = 1'b0;
    dmem_stall = 1'b0;
    imem_stall = 1'b0;
    instr_fd   = isa_pkg::NOP_WORD;
    wb         = '0;
    pc_src     = 1'b0;
    ex         = '0;
    chk_en     = 1'b0;
    chk_read   = 1'b0;
    exp_instr  = isa_pkg::NOP_WORD;
    exp_hazard = 1'b0;
    exp_flush  = 1'b0;
    exp_read   = '0;
    test_name  = "reset";
    checks     = 0;
    errors     = 0;
    cycles     = 0;
    repeat (2) @(posedge clk);
    arst_n    <= 1'b1;
    test_name <= "random";
    for (int i = 0; i < 200; i++) begin
      lcg_state = lcg_next(lcg_state);
      apply(lcg_state[30:15], 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, lcg_state[30:15], 1'b0, 1'b0);
    end
    test_name <= "regfile";
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      lcg_state = lcg_next(lcg_state);
      write_read(r[2:0], lcg_state[23:8]);
    end
    test_name <= "load_use";
    apply(w_load, 1'b1, 3'd3, 1'b0, 1'b0, 1'b0, isa_pkg::NOP_WORD, 1'b1, 1'b0);
    chk_read  <= 1'b0;
    apply(w_next, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, w_load, 1'b0, 1'b0);  // Replay
    apply(w_next, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, w_next, 1'b0, 1'b0);
    test_name <= "flush";
    apply(w_next, 1'b0, 3'd0, 1'b1, 1'b0, 1'b0, isa_pkg::NOP_WORD, 1'b0, 1'b1);
    apply(w_load, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, isa_pkg::NOP_WORD, 1'b0, 1'b1);
    apply(w_next, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, w_next, 1'b0, 1'b0);
    test_name <= "stall";
    apply(w_load, 1'b1, 3'd3, 1'b0, 1'b1, 1'b0, isa_pkg::NOP_WORD, 1'b0, 1'b0);
    apply(w_load, 1'b1, 3'd3, 1'b0, 1'b0, 1'b1, w_load, 1'b0, 1'b0);
    apply(w_next, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, w_next, 1'b0, 1'b0);
    @(posedge clk);
    chk_en <= 1'b0;
    $display("Checks done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
logic/isa_pkg.sv
logic/instr_decoder.sv
logic/reg_file_bypass.sv
logic/load_use_hazard.sv
logic/decode_stage.sv
tb/decode_stage_assert.sv
tb/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
BIN=decode_stage_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_stage_tb \
  -f src.f \
  --Mdir "$OBJ_DIR" -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Testbench reported failure, see $LOG"
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "Testbench ended without a result line, see $LOG"
  exit 1
fi

exit 0
